// File: hdl/cpuPkg.sv
`default_nettype none

package cpuPkg;

    // --------------------
    // Widths
    // --------------------
    localparam int wordWidth = 32;
    localparam int addrWidth = 16;
    localparam int numRegs = 16;
    localparam int regIdxWidth = $clog2(numRegs);

    // Program counter value after reset
    localparam int resetAddr = 0;

    // Data and instruction word
    typedef logic [wordWidth-1:0] word_t;
    // Instruction word address
    typedef logic [addrWidth-1:0] addr_t;
    // Register index
    typedef logic [regIdxWidth-1:0] regIdx_t;

    // Operation codes, top byte of the instruction
    typedef enum logic [7:0] {
        opNop  = 8'h00,
        opAdd  = 8'h01,
        opSub  = 8'h02,
        opAnd  = 8'h03,
        opOr   = 8'h04,
        opXor  = 8'h05,
        opAddi = 8'h06,
        opBeq  = 8'h07,
        opBne  = 8'h08
    } opcode_t;

    // --------------------
    // Field positions
    // --------------------
    localparam int opcodeHi = 31;
    localparam int opcodeLo = 24;
    localparam int rdHi = 23;
    localparam int rdLo = 20;
    localparam int rs1Hi = 19;
    localparam int rs1Lo = 16;
    localparam int rs2Hi = 15;
    localparam int rs2Lo = 12;
    // Immediate overlaps rs2, ADDI and branches have no rs2
    localparam int immHi = 15;
    localparam int immLo = 0;

endpackage

`default_nettype wire

// File: hdl/issueBus.sv
`timescale 1ns/1ps
`default_nettype none

// One decoded instruction, decode register to execute
interface issueBus;
    import cpuPkg::*;

    // Cleared valid is a bubble
    logic valid;
    opcode_t op;
    regIdx_t rd;
    // Operand values after forwarding
    word_t a;
    word_t b;
    // Sign-extended immediate for ADDI
    word_t imm;
    // Absolute branch target
    addr_t target;

    // Decode side
    modport source (
        output valid, op, rd, a, b, imm, target
    );

    // Execute side
    modport sink (
        input valid, op, rd, a, b, imm, target
    );

endinterface

`default_nettype wire

// File: hdl/regPort.sv
`timescale 1ns/1ps
`default_nettype none

// Register file access, two reads and one write
interface regPort;
    import cpuPkg::*;

    // Read ports, combinational
    regIdx_t rs1Addr;
    regIdx_t rs2Addr;
    word_t rs1Data;
    word_t rs2Data;

    // Write port, taken at the clock edge
    logic writeEn;
    regIdx_t writeReg;
    word_t writeData;

    modport reader (
        output rs1Addr, rs2Addr,
        input  rs1Data, rs2Data
    );

    modport writer (
        output writeEn, writeReg, writeData
    );

    modport file (
        input  rs1Addr, rs2Addr, writeEn, writeReg, writeData,
        output rs1Data, rs2Data
    );

endinterface

`default_nettype wire

// File: hdl/fetchStage.sv
`timescale 1ns/1ps
`default_nettype none

module fetchStage (
    input  logic          Clock,
    input  logic          reset,
    input  logic          stall,
    input  logic          branchTaken,
    input  cpuPkg::addr_t branchAddr,
    input  cpuPkg::word_t instrData,
    output cpuPkg::addr_t instrAddr,
    output logic          fetchValid,
    output cpuPkg::word_t fetchInstr
);
    import cpuPkg::*;

    // Program counter and its candidates
    addr_t pc;
    addr_t pcInc;
    addr_t pcHold;
    addr_t pcNext;

    // --------------------
    // Next address
    // --------------------

    // Sequential step, one word per cycle
    assign pcInc = pc + addr_t'(1);

    // Stall keeps the current address
    assign pcHold = stall ? pc : pcInc;

    // Redirect wins over stall
    assign pcNext = branchTaken ? branchAddr : pcHold;

    always_ff @(posedge Clock) begin
        if (reset) begin
            pc <= addr_t'(resetAddr);
        end else begin
            pc <= pcNext;
        end
    end

    // Memory answers in the same cycle
    assign instrAddr = pc;

    // --------------------
    // Fetch register
    // --------------------

    // Bubble on stall or when the fetched word is on the wrong path
    always_ff @(posedge Clock) begin
        if (reset) begin
            fetchValid <= 1'b0;
        end else begin
            fetchValid <= !stall && !branchTaken;
        end
    end

    // Word is only looked at when fetchValid is set
    always_ff @(posedge Clock) begin
        fetchInstr <= instrData;
    end

    // Redirect comes from execute and steers the PC mux every cycle
    branchKnown: assert property (
        @(posedge Clock) disable iff (reset)
        !$isunknown(branchTaken)
    );

endmodule

`default_nettype wire

// File: hdl/decodeStage.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
    input  logic            Clock,
    input  logic            reset,
    input  logic            fetchValid,
    input  logic            branchTaken,
    input  cpuPkg::word_t   fetchInstr,
    regPort.reader          rf,
    input  logic            fwdEn,
    input  cpuPkg::regIdx_t fwdReg,
    input  cpuPkg::word_t   fwdData,
    issueBus.source         iss
);
    import cpuPkg::*;

    localparam int immWidth = immHi - immLo + 1;

    // Raw fields
    logic [opcodeHi-opcodeLo:0] opRaw;
    regIdx_t rd;
    regIdx_t rs1;
    regIdx_t rs2;
    logic [immWidth-1:0] imm16;

    // Decoded values
    opcode_t op;
    logic isBranch;
    word_t immExt;
    word_t opA;
    word_t opB;

    // --------------------
    // Field extraction
    // --------------------
    assign opRaw = fetchInstr[opcodeHi:opcodeLo];
    assign rd = fetchInstr[rdHi:rdLo];
    assign rs1 = fetchInstr[rs1Hi:rs1Lo];
    assign rs2 = fetchInstr[rs2Hi:rs2Lo];
    assign imm16 = fetchInstr[immHi:immLo];

    // Anything outside the set runs as NOP
    always_comb begin
        case (opRaw)
            opAdd, opSub, opAnd, opOr, opXor, opAddi, opBeq, opBne:
                op = opcode_t'(opRaw);
            default:
                op = opNop;
        endcase
    end

    assign isBranch = (op == opBeq) || (op == opBne);

    // ADDI takes the immediate as signed
    assign immExt = {{(wordWidth - immWidth){imm16[immWidth-1]}}, imm16};

    // --------------------
    // Register read
    // --------------------

    // Branches compare rd with rs1
    assign rf.rs1Addr = isBranch ? rd : rs1;
    assign rf.rs2Addr = isBranch ? rs1 : rs2;

    // Result still in execute overrides the stale file value
    assign opA = (fwdEn && fwdReg == rf.rs1Addr) ? fwdData : rf.rs1Data;
    assign opB = (fwdEn && fwdReg == rf.rs2Addr) ? fwdData : rf.rs2Data;

    // --------------------
    // Decode register
    // --------------------
    always_ff @(posedge Clock) begin
        if (reset) begin
            iss.valid <= 1'b0;
        end else begin
            // Taken branch kills the instruction behind it
            iss.valid <= fetchValid && !branchTaken;
        end
    end

    always_ff @(posedge Clock) begin
        iss.op <= op;
        iss.rd <= rd;
        iss.a <= opA;
        iss.b <= opB;
        iss.imm <= immExt;
        iss.target <= addr_t'(imm16);
    end

    // Both slots behind a taken branch reach execute as bubbles
    flushDone: assert property (
        @(posedge Clock) disable iff (reset)
        (branchTaken || $past(branchTaken)) |=> !iss.valid
    );

endmodule

`default_nettype wire

// File: hdl/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input logic Clock,
    input logic reset,
    regPort.file rp
);
    import cpuPkg::*;

    // Register zero is kept but never written
    word_t regs [numRegs];

    // --------------------
    // Write port
    // --------------------
    always_ff @(posedge Clock) begin
        if (reset) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (rp.writeEn && rp.writeReg != '0) begin
            regs[rp.writeReg] <= rp.writeData;
        end
    end

    // --------------------
    // Read ports
    // --------------------

    // Index zero forced to zero on both ports
    always_comb begin
        if (rp.rs1Addr == '0) begin
            rp.rs1Data = '0;
        end else begin
            rp.rs1Data = regs[rp.rs1Addr];
        end
    end

    always_comb begin
        if (rp.rs2Addr == '0) begin
            rp.rs2Data = '0;
        end else begin
            rp.rs2Data = regs[rp.rs2Addr];
        end
    end

endmodule

`default_nettype wire

// File: hdl/executeStage.sv
`timescale 1ns/1ps
`default_nettype none

module executeStage (
    issueBus.sink           iss,
    regPort.writer          rp,
    output logic            branchTaken,
    output cpuPkg::addr_t   branchAddr,
    output logic            fwdEn,
    output cpuPkg::regIdx_t fwdReg,
    output cpuPkg::word_t   fwdData,
    output logic            wbValid,
    output cpuPkg::regIdx_t wbReg,
    output cpuPkg::word_t   wbData
);
    import cpuPkg::*;

    word_t aluOut;
    logic isAluOp;
    logic equal;
    logic writes;

    // --------------------
    // ALU
    // --------------------
    always_comb begin
        case (iss.op)
            opAdd:   aluOut = iss.a + iss.b;
            opSub:   aluOut = iss.a - iss.b;
            opAnd:   aluOut = iss.a & iss.b;
            opOr:    aluOut = iss.a | iss.b;
            opXor:   aluOut = iss.a ^ iss.b;
            opAddi:  aluOut = iss.a + iss.imm;
            default: aluOut = '0;
        endcase
    end

    // Operations that produce a register result
    always_comb begin
        case (iss.op)
            opAdd, opSub, opAnd, opOr, opXor, opAddi:
                isAluOp = 1'b1;
            default:
                isAluOp = 1'b0;
        endcase
    end

    // --------------------
    // Branch resolution
    // --------------------

    // For branches a holds rd and b holds rs1
    assign equal = (iss.a == iss.b);

    always_comb begin
        branchTaken = 1'b0;
        if (iss.valid) begin
            if (iss.op == opBeq) begin
                branchTaken = equal;
            end else if (iss.op == opBne) begin
                branchTaken = !equal;
            end
        end
    end

    // Absolute word address from the immediate
    assign branchAddr = iss.target;

    // --------------------
    // Writeback
    // --------------------

    // Writes to register zero are dropped here
    assign writes = iss.valid && isAluOp && (iss.rd != '0);

    assign rp.writeEn = writes;
    assign rp.writeReg = iss.rd;
    assign rp.writeData = aluOut;

    // Same result goes back to decode
    assign fwdEn = writes;
    assign fwdReg = iss.rd;
    assign fwdData = aluOut;

    // Visible at the top in the cycle the file is written
    assign wbValid = writes;
    assign wbReg = iss.rd;
    assign wbData = aluOut;

endmodule

`default_nettype wire

// File: hdl/cpuCore.sv
`timescale 1ns/1ps
`default_nettype none

module cpuCore (
    input  logic            Clock,
    input  logic            reset,
    input  logic            stall,
    output cpuPkg::addr_t   instrAddr,
    input  cpuPkg::word_t   instrData,
    output logic            wbValid,
    output cpuPkg::regIdx_t wbReg,
    output cpuPkg::word_t   wbData
);
    import cpuPkg::*;

    // Fetch to decode
    logic fetchValid;
    word_t fetchInstr;

    // Redirect from execute
    logic branchTaken;
    addr_t branchAddr;

    // Forwarding path, execute to decode
    logic fwdEn;
    regIdx_t fwdReg;
    word_t fwdData;

    // --------------------
    // Buses
    // --------------------
    issueBus iss ();
    regPort rp ();

    // --------------------
    // Stages
    // --------------------
    fetchStage fetch (
        .Clock       (Clock),
        .reset       (reset),
        .stall       (stall),
        .branchTaken (branchTaken),
        .branchAddr  (branchAddr),
        .instrData   (instrData),
        .instrAddr   (instrAddr),
        .fetchValid  (fetchValid),
        .fetchInstr  (fetchInstr)
    );

    decodeStage decode (
        .Clock       (Clock),
        .reset       (reset),
        .fetchValid  (fetchValid),
        .branchTaken (branchTaken),
        .fetchInstr  (fetchInstr),
        .rf          (rp.reader),
        .fwdEn       (fwdEn),
        .fwdReg      (fwdReg),
        .fwdData     (fwdData),
        .iss         (iss.source)
    );

    regFile regs (
        .Clock (Clock),
        .reset (reset),
        .rp    (rp.file)
    );

    executeStage execute (
        .iss         (iss.sink),
        .rp          (rp.writer),
        .branchTaken (branchTaken),
        .branchAddr  (branchAddr),
        .fwdEn       (fwdEn),
        .fwdReg      (fwdReg),
        .fwdData     (fwdData),
        .wbValid     (wbValid),
        .wbReg       (wbReg),
        .wbData      (wbData)
    );

endmodule

`default_nettype wire

// File: tests/cpuCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module cpuCoreTb;
    import cpuPkg::*;

    // Program space and table sizes
    localparam int progLen = 16;
    localparam int numExpected = 10;
    localparam int resetCycles = 5;
    // Cycles allowed between two writebacks
    localparam int wbTimeout = 64;
    // Silent cycles required after the last result
    localparam int quietCycles = 40;
    // Writebacks seen before the mid-program reset
    localparam int partialCount = 5;

    logic Clock;
    logic reset;
    logic stall;
    addr_t instrAddr;
    word_t instrData;
    logic wbValid;
    regIdx_t wbReg;
    word_t wbData;

    int checkCount;
    int errorCount;
    bit aborted;
    logic [31:0] rndState;

    // --------------------
    // Program table
    // --------------------
    // opcode[31:24] rd[23:20] rs1[19:16] rs2[15:12] imm[15:0]
    word_t progMem [progLen] = '{
        32'h06100005,  // 0  ADDI r1, r0, 5
        32'h06200003,  // 1  ADDI r2, r0, 3
        32'h01312000,  // 2  ADD  r3, r1, r2
        32'h02432000,  // 3  SUB  r4, r3, r2   forwarded r3
        32'h03543000,  // 4  AND  r5, r4, r3   forwarded r4
        32'h04643000,  // 5  OR   r6, r4, r3
        32'h05761000,  // 6  XOR  r7, r6, r1   forwarded r6
        32'h06010007,  // 7  ADDI r0, r1, 7    no writeback
        32'h01801000,  // 8  ADD  r8, r0, r1   r0 reads zero
        32'h0690ffff,  // 9  ADDI r9, r0, -1
        32'h0714000d,  // 10 BEQ  r1, r4, 13   taken
        32'h06a00001,  // 11 ADDI r10, r0, 1   flushed
        32'h06b00002,  // 12 ADDI r11, r0, 2   flushed
        32'h0814000b,  // 13 BNE  r1, r4, 11   not taken
        32'h06c90002,  // 14 ADDI r12, r9, 2
        32'h0700000f   // 15 BEQ  r0, r0, 15   spin here
    };

    // --------------------
    // Expected writebacks
    // --------------------
    regIdx_t expReg [numExpected] = '{
        4'd1, 4'd2, 4'd3, 4'd4, 4'd5, 4'd6, 4'd7, 4'd8, 4'd9, 4'd12
    };
    word_t expData [numExpected] = '{
        32'h00000005,  // 5
        32'h00000003,  // 3
        32'h00000008,  // 5 + 3
        32'h00000005,  // 8 - 3
        32'h00000000,  // 5 & 8
        32'h0000000d,  // 5 | 8
        32'h00000008,  // 13 ^ 5
        32'h00000005,  // 0 + 5
        32'hffffffff,  // sign-extended -1
        32'h00000001   // -1 + 2
    };

    // Instruction memory answering in the same cycle with NOP past the end
    assign instrData = (instrAddr < addr_t'(progLen)) ? progMem[instrAddr[3:0]] : '0;

    cpuCore DUT (
        .Clock     (Clock),
        .reset     (reset),
        .stall     (stall),
        .instrAddr (instrAddr),
        .instrData (instrData),
        .wbValid   (wbValid),
        .wbReg     (wbReg),
        .wbData    (wbData)
    );

    initial begin
        Clock = 1'b0;
        forever #50 Clock = ~Clock;
    end

    // --------------------
    // Helpers
    // --------------------
    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic checkValue(input string name, input word_t expected, input word_t actual);
        checkCount++;
        if (actual !== expected) begin
            $display("** Error at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
            errorCount++;
        end
    endtask

    // One clock with new stall on the rising edge and outputs sampled on the falling edge
    task automatic stepCycle(input bit randomStall);
        @(posedge Clock);
        if (randomStall) begin
            rndState = xorshift(rndState);
            // Roughly one cycle in four
            stall <= (rndState[1:0] == 2'b00);
        end else begin
            stall <= 1'b0;
        end
        @(negedge Clock);
    endtask

    // Five reset cycles with PC and writeback checked after each edge
    task automatic applyReset();
        int i;
        @(posedge Clock);
        reset <= 1'b1;
        stall <= 1'b0;
        for (i = 0; i < resetCycles; i++) begin
            @(posedge Clock);
            if (i == resetCycles - 1) begin
                reset <= 1'b0;
            end
            @(negedge Clock);
            checkValue("instrAddr", word_t'(0), word_t'(instrAddr));
            checkValue("wbValid", word_t'(1'b0), word_t'(wbValid));
        end
    endtask

    task automatic waitWriteback(input bit randomStall, output bit got);
        int cycles;
        cycles = 0;
        got = 1'b0;
        while (!got && cycles < wbTimeout) begin
            stepCycle(randomStall);
            cycles++;
            if (wbValid) begin
                got = 1'b1;
            end
        end
    endtask

    // Core spins on its last branch so nothing more may be written
    task automatic checkQuiet(input bit randomStall);
        int i;
        for (i = 0; i < quietCycles; i++) begin
            stepCycle(randomStall);
            if (wbValid) begin
                $display("Unexpected writeback of r%0d at %0t after the program ended",
                         wbReg, $time);
                errorCount++;
            end
        end
    endtask

    // Reset and compare the first count writebacks with the table
    task automatic runPass(input bit randomStall, input int count);
        bit got;
        int k;
        applyReset();
        for (k = 0; k < count && !aborted; k++) begin
            waitWriteback(randomStall, got);
            if (!got) begin
                $display("Timeout at %0t: writeback %0d did not appear within %0d cycles",
                         $time, k, wbTimeout);
                errorCount++;
                aborted = 1'b1;
            end else begin
                checkValue("wbReg", word_t'(expReg[k]), word_t'(wbReg));
                checkValue("wbData", expData[k], wbData);
            end
        end
        if (!aborted && count == numExpected) begin
            checkQuiet(randomStall);
        end
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        reset = 1'b1;
        stall = 1'b0;
        checkCount = 0;
        errorCount = 0;
        aborted = 1'b0;
        rndState = 32'hcc75;

        // Free-running pipeline
        runPass(1'b0, numExpected);
        // Same program under random stall
        if (!aborted) begin
            runPass(1'b1, numExpected);
        end
        // Cut off midway and restart in full from address 0
        if (!aborted) begin
            runPass(1'b1, partialCount);
        end
        if (!aborted) begin
            runPass(1'b1, numExpected);
        end

        $display("checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
hdl/cpuPkg.sv
hdl/issueBus.sv
hdl/regPort.sv
hdl/fetchStage.sv
hdl/decodeStage.sv
hdl/regFile.sv
hdl/executeStage.sv
hdl/cpuCore.sv
tests/cpuCoreTb.sv

// File: run.sh
#!/bin/sh
# Build and run the cpuCore testbench with Verilator
verilator --binary --timing --timescale 1ns/1ps --top-module cpuCoreTb \
    -f list.f --Mdir obj_dir -o cpuCoreSim \
    && ./obj_dir/cpuCoreSim 2>&1 | tee sim.log \
    && ! grep -q "sim failed" sim.log \
    && grep -q "sim passed" sim.log \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
